/* bench/bpu_model.svh */
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

logic [1:0]        ref_pht [PHT_ENTRIES];
logic              ref_btb_valid [BTB_ENTRIES];
logic [XLEN-1:0]   ref_btb_pc [BTB_ENTRIES];  // full pc, tag taken from it
logic [XLEN-1:0]   ref_btb_target [BTB_ENTRIES];
logic [XLEN-1:0]   ref_ras [$];               // back of the queue is the top
logic [HISLEN-1:0] ref_hist;

// jalr, rd = x0, rs1 = x1 or x5
function automatic logic is_ret_word(input logic [XLEN-1:0] w);
  return (w[6:0] == OPC_JALR) && (w[11:7] == 5'd0) &&
         ((w[19:15] == 5'd1) || (w[19:15] == 5'd5));
endfunction

function automatic void clear_tables();
  for (int i = 0; i < PHT_ENTRIES; i++) begin
    ref_pht[i] = PHT_INIT;
  end
  for (int i = 0; i < BTB_ENTRIES; i++) begin
    ref_btb_valid[i] = 1'b0;
  end
  ref_ras.delete();
  ref_hist = '0;
endfunction

task automatic predict_next(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] w,
                            output logic res, output logic [XLEN-1:0] tgt,
                            output pdt_src_e src);
  logic [XLEN-1:0]      imm;
  logic [PHT_IDX_W-1:0] pi;
  logic [BTB_IDX_W-1:0] bi;
  res = 1'b0;
  tgt = '0;
  src = SRC_DECODE;
  if (w[6:0] == OPC_JAL) begin
    imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    res = 1'b1;
    tgt = pc + imm;
  end else if (w[6:0] == OPC_BRANCH) begin
    imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    pi = pc[PHT_IDX_W+1:2] ^ ref_hist;
    res = ref_pht[pi][1];  // upper counter bit is the direction
    tgt = pc + imm;
  end else if (w[6:0] == OPC_JALR) begin
    src = SRC_TABLE;
    if (is_ret_word(w)) begin
      res = (ref_ras.size() > 0);
      if (res) tgt = ref_ras[$];
    end else begin
      bi = pc[BTB_IDX_W+1:2];
      res = ref_btb_valid[bi] && (ref_btb_pc[bi][XLEN-1:6] == pc[XLEN-1:6]);
      tgt = ref_btb_target[bi];
    end
  end
endtask

// same edge as the dut, push is never held off by the ex stall
task automatic train_tables(input logic br_valid, input logic stall, input logic taken,
                            input logic [XLEN-1:0] pc, input logic [HISLEN-1:0] hist,
                            input jump_type_e jt, input logic [XLEN-1:0] target,
                            input logic [XLEN-1:0] w, input logic push,
                            input logic [XLEN-1:0] push_data);
  logic                 pop;
  logic [PHT_IDX_W-1:0] pi;
  logic [BTB_IDX_W-1:0] bi;
  pop = 1'b0;
  if (br_valid && !stall) begin
    if (jt == JT_BRANCH) begin
      pi = pc[PHT_IDX_W+1:2] ^ hist;
      if (taken && ref_pht[pi] != 2'b11) ref_pht[pi] = ref_pht[pi] + 2'b01;
      if (!taken && ref_pht[pi] != 2'b00) ref_pht[pi] = ref_pht[pi] - 2'b01;
      ref_hist = {ref_hist[HISLEN-2:0], taken};
    end else if (jt == JT_JALR && is_ret_word(w)) begin
      pop = (ref_ras.size() > 0);  // empty pop dropped
    end else if (jt == JT_JALR) begin
      bi = pc[BTB_IDX_W+1:2];
      ref_btb_valid[bi] = 1'b1;
      ref_btb_pc[bi] = pc;
      ref_btb_target[bi] = target;
    end
  end
  if (push && pop) begin
    ref_ras[ref_ras.size()-1] = push_data;
  end else if (push) begin
    ref_ras.push_back(push_data);
    if (ref_ras.size() > RAS_DEPTH) void'(ref_ras.pop_front());  // oldest lost
  end else if (pop) begin
    void'(ref_ras.pop_back());
  end
endtask

`endif

/* bench/ifu_tb.sv */
`timescale 1ns/1ps

module ifu_tb
  import rv_pkg::*, bpu_pkg::*;
();

  localparam int TOTAL_CYCLES = 2000;  // sum of all phase lengths below
  localparam int WATCHDOG_NS = (TOTAL_CYCLES + 10 + 200) * 10;

  logic              clk = 1'b0;
  logic              reset_i;
  logic [XLEN-1:0]   inst_addr_i;
  logic              if_rdata_valid_i;
  logic [XLEN-1:0]   if_rdata_i;
  logic              ex_branch_valid_i;
  logic              ex_branch_taken_i;
  logic [XLEN-1:0]   ex_pc_i;
  logic [HISLEN-1:0] ex_history_i;
  jump_type_e        ex_jump_type_i;
  logic [XLEN-1:0]   ex_target_i;
  logic [XLEN-1:0]   ex_inst_i;
  logic              id_ras_push_valid_i;
  logic [XLEN-1:0]   id_ras_push_data_i;
  logic              ex_stall_valid_i;

  logic                ram_stall_valid_if_o;
  logic [XLEN-1:0]     inst_addr_o;
  logic [XLEN-1:0]     inst_data_o;
  logic [TRAP_LEN-1:0] trap_bus_o;
  logic [XLEN-1:0]     bpu_pc_o;
  logic                bpu_pc_valid_o;
  logic                pdt_res_o;
  pdt_src_e            which_pdt_o;
  logic [HISLEN-1:0]   history_o;

  `include "bpu_model.svh"

  always #5 clk = ~clk;

  ifu ifu_inst (.*);

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_src(input string name, input pdt_src_e exp, input pdt_src_e act);
    if (act !== exp) begin
      $display("Error %s: expected %s, actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_hist(input string name, input logic [HISLEN-1:0] exp,
                            input logic [HISLEN-1:0] act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // 5 picks any kind, 6 picks jal or branch
  function automatic int pick_kind(input int k);
    if (k == 5) return int'($urandom % 5);
    if (k == 6) return ($urandom % 2 == 0) ? 1 : 2;
    return k;
  endfunction

  function automatic jump_type_e kind_to_jt(input int k);
    case (k)
      1: return JT_JAL;
      2: return JT_BRANCH;
      3, 4: return JT_JALR;
      default: return JT_NONE;
    endcase
  endfunction

  // 0 alu op, 1 jal, 2 branch, 3 plain jalr, 4 return
  function automatic logic [XLEN-1:0] make_word(input int k);
    logic [XLEN-1:0] w;
    w = $urandom;
    case (k)
      1: w[6:0] = OPC_JAL;
      2: w[6:0] = OPC_BRANCH;
      3: begin
        w[6:0] = OPC_JALR;
        w[7] = 1'b1;  // rd never x0
      end
      4: begin
        w[6:0] = OPC_JALR;
        w[11:7] = 5'd0;
        w[19:15] = w[31] ? 5'd1 : 5'd5;
      end
      default: w[6:0] = 7'b0110011;
    endcase
    return w;
  endfunction

  // small pc pool so training and lookups collide, four tags per btb index
  function automatic logic [XLEN-1:0] pick_pc(input bit any_addr);
    logic [31:0] r;
    r = $urandom;
    if (any_addr) return r;
    return (r[31] ? 32'h8000_2000 : 32'h0000_1000) + {25'd0, r[4:0], 2'b00};
  endfunction

  task automatic compare_outputs(input string name);
    logic                res;
    logic [XLEN-1:0]     tgt;
    pdt_src_e            src;
    logic [TRAP_LEN-1:0] exp_trap;
    predict_next(inst_addr_i, if_rdata_i, res, tgt, src);
    exp_trap = '0;
    exp_trap[TRAP_INST_ADDR_MISALIGNED] = |inst_addr_i[1:0];
    check_addr({name, " inst_addr"}, inst_addr_i, inst_addr_o);
    check_addr({name, " inst_data"}, if_rdata_i, inst_data_o);
    check_bit({name, " stall"}, ~if_rdata_valid_i, ram_stall_valid_if_o);
    for (int b = 0; b < TRAP_LEN; b++) begin
      check_bit({name, " trap"}, exp_trap[b[3:0]], trap_bus_o[b[3:0]]);
    end
    check_bit({name, " pdt_res"}, res, pdt_res_o);
    check_bit({name, " pc_valid"}, res & if_rdata_valid_i, bpu_pc_valid_o);
    if (res) begin
      check_addr({name, " target"}, tgt, bpu_pc_o);
      check_src({name, " source"}, src, which_pdt_o);
    end
    check_hist({name, " history"}, ref_hist, history_o);
  endtask

  task automatic run_phase(input string name, input int cycles, input int fetch_kind,
                           input int train_kind, input int taken_pct, input int stall_pct,
                           input int push_pct, input int valid_pct, input bit any_addr);
    int tk;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      tk = pick_kind(train_kind);
      inst_addr_i <= pick_pc(any_addr);
      if_rdata_i <= make_word(pick_kind(fetch_kind));
      if_rdata_valid_i <= ($urandom % 100) < valid_pct;
      ex_branch_valid_i <= ($urandom % 100) < 80;
      ex_branch_taken_i <= ($urandom % 100) < taken_pct;
      ex_pc_i <= pick_pc(1'b0);
      ex_history_i <= (($urandom % 4) != 0) ? ref_hist : HISLEN'($urandom);
      ex_jump_type_i <= kind_to_jt(tk);
      ex_inst_i <= make_word(tk);
      ex_target_i <= {$urandom} & 32'hFFFF_FFFC;
      ex_stall_valid_i <= ($urandom % 100) < stall_pct;
      id_ras_push_valid_i <= ($urandom % 100) < push_pct;
      id_ras_push_data_i <= {$urandom} & 32'hFFFF_FFFC;
      @(negedge clk);
      compare_outputs(name);
      train_tables(ex_branch_valid_i, ex_stall_valid_i, ex_branch_taken_i, ex_pc_i,
                   ex_history_i, ex_jump_type_i, ex_target_i, ex_inst_i,
                   id_ras_push_valid_i, id_ras_push_data_i);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired before the tests finished");
    abort_run();
  end

  initial begin
    void'($urandom(32'h7938));
    clear_tables();
    reset_i = 1'b1;
    inst_addr_i = '0;
    if_rdata_valid_i = 1'b0;
    if_rdata_i = '0;
    ex_branch_valid_i = 1'b0;
    ex_branch_taken_i = 1'b0;
    ex_pc_i = '0;
    ex_history_i = '0;
    ex_jump_type_i = JT_NONE;
    ex_target_i = '0;
    ex_inst_i = '0;
    id_ras_push_valid_i = 1'b0;
    id_ras_push_data_i = '0;
    ex_stall_valid_i = 1'b0;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    // name, cycles, fetch, train, taken%, stall%, push%, valid%, any addr
    run_phase("pass_through", 200, 5, 5, 50, 25, 30, 50, 1'b0);
    run_phase("trap_bus", 200, 5, 5, 50, 25, 30, 80, 1'b1);
    run_phase("direct_taken", 300, 6, 2, 90, 10, 0, 90, 1'b0);
    run_phase("direct_not_taken", 300, 6, 2, 10, 10, 0, 90, 1'b0);
    run_phase("history", 300, 2, 2, 50, 50, 0, 90, 1'b0);
    run_phase("indirect", 300, 3, 3, 50, 25, 0, 90, 1'b0);
    run_phase("return_fill", 200, 4, 4, 50, 25, 80, 90, 1'b0);
    run_phase("return_drain", 200, 4, 4, 50, 25, 20, 90, 1'b0);
    $display("Test passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+bench
verilog/rv_pkg.sv
verilog/bpu_pkg.sv
verilog/bpu_update_if.sv
verilog/pht_counters.sv
verilog/btb.sv
verilog/ras.sv
verilog/bpu.sv
verilog/ifu.sv
bench/ifu_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -sv --top-module ifu_tb -f files.f -Mdir obj_dir -o ifu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ifu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

/* verilog/bpu.sv */
`timescale 1ns/1ps

module bpu
  import rv_pkg::*, bpu_pkg::*;
(
  input  logic              clk,
  input  logic              reset_i,
  input  logic [XLEN-1:0]   if_pc_i,
  input  logic [XLEN-1:0]   if_inst_i,
  input  logic              flush_i,
  bpu_update_if.sink        upd,
  output logic [XLEN-1:0]   pdt_pc_o,
  output logic              pdt_valid_o,
  output logic              pdt_res_o,
  output pdt_src_e          which_pdt_o,
  output logic [HISLEN-1:0] history_o
);

  jump_type_e        if_jt;
  logic [XLEN-1:0]   imm_j;
  logic [XLEN-1:0]   imm_b;
  logic              if_is_ret;
  logic              pht_taken;
  logic              btb_hit;
  logic [XLEN-1:0]   btb_target;
  logic [XLEN-1:0]   ras_top;
  logic              ras_empty;
  logic [HISLEN-1:0] hist_q;

  // light decode of the fetched word
  always_comb begin
    case (if_inst_i[6:0])
      OPC_JAL:    if_jt = JT_JAL;
      OPC_JALR:   if_jt = JT_JALR;
      OPC_BRANCH: if_jt = JT_BRANCH;
      default:    if_jt = JT_NONE;
    endcase
  end

  assign imm_j = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20], if_inst_i[30:21], 1'b0};
  assign imm_b = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25], if_inst_i[11:8], 1'b0};
  assign if_is_ret = is_return(if_inst_i);

  // pdt_pc_o falls through to pc + 4 unless a taken target is chosen
  always_comb begin
    pdt_res_o = 1'b0;
    pdt_pc_o = if_pc_i + XLEN'(4);
    which_pdt_o = SRC_DECODE;
    case (if_jt)
      JT_JAL: begin
        pdt_res_o = 1'b1;
        pdt_pc_o = if_pc_i + imm_j;
      end
      JT_BRANCH: begin
        pdt_res_o = pht_taken;  // counter msb
        if (pht_taken) begin
          pdt_pc_o = if_pc_i + imm_b;
        end
      end
      JT_JALR: begin
        which_pdt_o = SRC_TABLE;
        if (if_is_ret) begin
          pdt_res_o = !ras_empty;
          if (!ras_empty) begin
            pdt_pc_o = ras_top;
          end
        end else begin
          pdt_res_o = btb_hit;
          if (btb_hit) begin
            pdt_pc_o = btb_target;
          end
        end
      end
      default: pdt_res_o = 1'b0;  // not a control transfer
    endcase
  end

  assign pdt_valid_o = pdt_res_o & ~flush_i;

  // global history, shifted on resolved conditional branches only
  always_ff @(posedge clk) begin
    if (reset_i) begin
      hist_q <= '0;
    end else if (upd.train && (upd.ex_jump_type == JT_BRANCH)) begin
      hist_q <= {hist_q[HISLEN-2:0], upd.ex_taken};
    end
  end

  assign history_o = hist_q;

  pht_counters u_pht (
    .clk          (clk),
    .reset_i      (reset_i),
    .lookup_idx_i (if_pc_i[PHT_IDX_W+1:2]),
    .upd          (upd),
    .history_i    (hist_q),
    .taken_o      (pht_taken)
  );

  btb u_btb (
    .clk         (clk),
    .reset_i     (reset_i),
    .lookup_pc_i (if_pc_i),
    .upd         (upd),
    .hit_o       (btb_hit),
    .target_o    (btb_target)
  );

  ras u_ras (
    .clk     (clk),
    .reset_i (reset_i),
    .upd     (upd),
    .top_o   (ras_top),
    .empty_o (ras_empty)
  );

endmodule

/* verilog/bpu_pkg.sv */
package bpu_pkg;

  localparam int HISLEN = 8;  // global history, same width as the pht index

  localparam int PHT_ENTRIES = 256;
  localparam int PHT_IDX_W = $clog2(PHT_ENTRIES);
  localparam logic [1:0] PHT_INIT = 2'b01;  // weakly not taken

  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W = 26;  // pc[31:6]

  // stack depth kept a power of two so the pointer wraps by itself
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = $clog2(RAS_DEPTH);
  localparam int RAS_CNT_W = $clog2(RAS_DEPTH + 1);

  // where the predicted target came from
  typedef enum logic {
    SRC_DECODE = 1'b0,
    SRC_TABLE  = 1'b1
  } pdt_src_e;

endpackage

/* verilog/bpu_update_if.sv */
`timescale 1ns/1ps

interface bpu_update_if
  import rv_pkg::*, bpu_pkg::*;
();

  logic              ex_branch_valid;  // resolution strobe from EX
  logic              ex_taken;
  logic [XLEN-1:0]   ex_pc;
  logic [HISLEN-1:0] ex_history;       // history seen at prediction time
  jump_type_e        ex_jump_type;
  logic [XLEN-1:0]   ex_target;
  logic [XLEN-1:0]   ex_inst;
  logic              ex_stall;
  logic              ras_push_valid;   // call seen in ID
  logic [XLEN-1:0]   ras_push_data;

  // qualified training strobe and return flag, shared by all tables
  logic train;
  logic ex_is_ret;

  assign train = ex_branch_valid & ~ex_stall;
  assign ex_is_ret = is_return(ex_inst);

  modport src (
    output ex_branch_valid, ex_taken, ex_pc, ex_history, ex_jump_type,
           ex_target, ex_inst, ex_stall, ras_push_valid, ras_push_data
  );

  modport sink (
    input train, ex_taken, ex_pc, ex_history, ex_jump_type,
          ex_target, ex_is_ret, ras_push_valid, ras_push_data
  );

endinterface

/* verilog/btb.sv */
`timescale 1ns/1ps

module btb
  import rv_pkg::*, bpu_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  input  logic [XLEN-1:0] lookup_pc_i,
  bpu_update_if.sink      upd,
  output logic            hit_o,
  output logic [XLEN-1:0] target_o
);

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0]   rd_idx;
  logic [BTB_TAG_W-1:0]   rd_tag;
  logic [BTB_IDX_W-1:0]   wr_idx;
  logic [BTB_TAG_W-1:0]   wr_tag;
  logic                   wr_en;

  // direct mapped, index pc[5:2], tag pc[31:6]
  assign rd_idx = lookup_pc_i[BTB_IDX_W+1:2];
  assign rd_tag = lookup_pc_i[XLEN-1:XLEN-BTB_TAG_W];

  assign hit_o = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = target_q[rd_idx];

  assign wr_idx = upd.ex_pc[BTB_IDX_W+1:2];
  assign wr_tag = upd.ex_pc[XLEN-1:XLEN-BTB_TAG_W];

  // returns go to the ras instead
  assign wr_en = upd.train && (upd.ex_jump_type == JT_JALR) && !upd.ex_is_ret;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // tag and target storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_idx] <= wr_tag;
      target_q[wr_idx] <= upd.ex_target;  // last seen target wins
    end
  end

endmodule

/* verilog/ifu.sv */
`timescale 1ns/1ps

module ifu
  import rv_pkg::*, bpu_pkg::*;
(
  input  logic                clk,
  input  logic                reset_i,
  input  logic [XLEN-1:0]     inst_addr_i,          // from pc register
  input  logic                if_rdata_valid_i,
  input  logic [XLEN-1:0]     if_rdata_i,
  input  logic                ex_branch_valid_i,
  input  logic                ex_branch_taken_i,
  input  logic [XLEN-1:0]     ex_pc_i,
  input  logic [HISLEN-1:0]   ex_history_i,
  input  jump_type_e          ex_jump_type_i,
  input  logic [XLEN-1:0]     ex_target_i,
  input  logic [XLEN-1:0]     ex_inst_i,
  input  logic                id_ras_push_valid_i,  // call seen in decode
  input  logic [XLEN-1:0]     id_ras_push_data_i,
  input  logic                ex_stall_valid_i,
  output logic                ram_stall_valid_if_o,
  output logic [XLEN-1:0]     inst_addr_o,
  output logic [XLEN-1:0]     inst_data_o,
  output logic [TRAP_LEN-1:0] trap_bus_o,
  output logic [XLEN-1:0]     bpu_pc_o,
  output logic                bpu_pc_valid_o,
  output logic                pdt_res_o,
  output pdt_src_e            which_pdt_o,
  output logic [HISLEN-1:0]   history_o
);

  logic ram_stall;

  // icache word not ready yet, hold the pipe
  assign ram_stall = ~if_rdata_valid_i;
  assign ram_stall_valid_if_o = ram_stall;

  assign inst_addr_o = inst_addr_i;
  assign inst_data_o = if_rdata_i;

  // only misalignment can be detected here
  always_comb begin
    trap_bus_o = '0;
    trap_bus_o[TRAP_INST_ADDR_MISALIGNED] = |inst_addr_i[1:0];
    trap_bus_o[TRAP_INST_ACCESS_FAULT] = 1'b0;  // no pmp
    trap_bus_o[TRAP_INST_PAGE_FAULT] = 1'b0;    // no mmu
  end

  bpu_update_if upd ();

  assign upd.ex_branch_valid = ex_branch_valid_i;
  assign upd.ex_taken = ex_branch_taken_i;
  assign upd.ex_pc = ex_pc_i;
  assign upd.ex_history = ex_history_i;
  assign upd.ex_jump_type = ex_jump_type_i;
  assign upd.ex_target = ex_target_i;
  assign upd.ex_inst = ex_inst_i;
  assign upd.ex_stall = ex_stall_valid_i;
  assign upd.ras_push_valid = id_ras_push_valid_i;
  assign upd.ras_push_data = id_ras_push_data_i;

  bpu u_bpu (
    .clk         (clk),
    .reset_i     (reset_i),
    .if_pc_i     (inst_addr_i),
    .if_inst_i   (if_rdata_i),
    .flush_i     (ram_stall),  // no redirect while the word is invalid
    .upd         (upd),
    .pdt_pc_o    (bpu_pc_o),
    .pdt_valid_o (bpu_pc_valid_o),
    .pdt_res_o   (pdt_res_o),
    .which_pdt_o (which_pdt_o),
    .history_o   (history_o)
  );

endmodule

/* verilog/pht_counters.sv */
`timescale 1ns/1ps

module pht_counters
  import rv_pkg::*, bpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic [PHT_IDX_W-1:0] lookup_idx_i,  // fetch pc[9:2]
  bpu_update_if.sink           upd,
  input  logic [HISLEN-1:0]    history_i,
  output logic                 taken_o
);

  logic [1:0]           cnt_q [PHT_ENTRIES];
  logic [PHT_IDX_W-1:0] rd_idx;
  logic [PHT_IDX_W-1:0] wr_idx;
  logic [1:0]           wr_cnt;
  logic                 wr_en;

  // gshare lookup
  assign rd_idx = lookup_idx_i ^ history_i;
  assign taken_o = cnt_q[rd_idx][1];

  // resolved branch indexes with the history it was predicted under
  assign wr_idx = upd.ex_pc[PHT_IDX_W+1:2] ^ upd.ex_history;
  assign wr_en = upd.train && (upd.ex_jump_type == JT_BRANCH);

  // saturating step of the addressed counter
  always_comb begin
    wr_cnt = cnt_q[wr_idx];
    if (upd.ex_taken) begin
      if (wr_cnt != 2'b11) begin
        wr_cnt = wr_cnt + 2'b01;
      end
    end else begin
      if (wr_cnt != 2'b00) begin
        wr_cnt = wr_cnt - 2'b01;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        cnt_q[i] <= PHT_INIT;
      end
    end else if (wr_en) begin
      cnt_q[wr_idx] <= wr_cnt;
    end
  end

endmodule

/* verilog/ras.sv */
`timescale 1ns/1ps

module ras
  import rv_pkg::*, bpu_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  bpu_update_if.sink      upd,
  output logic [XLEN-1:0] top_o,
  output logic            empty_o
);

  logic [XLEN-1:0]      stack_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] top_q;
  logic [RAS_PTR_W-1:0] top_nxt;
  logic [RAS_CNT_W-1:0] cnt_q;
  logic                 push;
  logic                 pop;

  assign push = upd.ras_push_valid;  // not held off by ex stall
  // a pop on an empty stack is dropped
  assign pop = upd.train && (upd.ex_jump_type == JT_JALR) && upd.ex_is_ret && !empty_o;

  assign top_nxt = top_q + 1'b1;
  assign top_o = stack_q[top_q];
  assign empty_o = (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      top_q <= '0;
      cnt_q <= '0;
    end else if (push && !pop) begin
      top_q <= top_nxt;  // wraps onto the oldest entry when full
      if (cnt_q != RAS_CNT_W'(RAS_DEPTH)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (pop && !push) begin
      top_q <= top_q - 1'b1;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // push with pop replaces the top in place
  always_ff @(posedge clk) begin
    if (push && pop) begin
      stack_q[top_q] <= upd.ras_push_data;
    end else if (push) begin
      stack_q[top_nxt] <= upd.ras_push_data;
    end
  end

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;
  localparam int TRAP_LEN = 16;

  // bit positions inside the trap bus
  localparam int TRAP_INST_ADDR_MISALIGNED = 0;
  localparam int TRAP_INST_ACCESS_FAULT = 1;
  localparam int TRAP_INST_PAGE_FAULT = 12;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

  // jalr with rd = x0 and rs1 = ra or t0
  function automatic logic is_return(input logic [XLEN-1:0] inst);
    logic [4:0] rd;
    logic [4:0] rs1;
    rd = inst[11:7];
    rs1 = inst[19:15];
    return (inst[6:0] == OPC_JALR) && (rd == 5'd0) && ((rs1 == 5'd1) || (rs1 == 5'd5));
  endfunction

endpackage
